// ==== hw/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// register and data width
`define CSR_XLEN 32

// trap vector base out of reset, direct mode
`define CSR_MTVEC_RESET 32'h0000_0100

// implemented mstatus fields
`define CSR_MSTATUS_MIE 3
`define CSR_MSTATUS_MPIE 7
// mpp occupies this bit and the one above
`define CSR_MSTATUS_MPP_LO 11

// mip and mie bit positions
`define CSR_IRQ_MSI 3
`define CSR_IRQ_MTI 7
`define CSR_IRQ_MEI 11

`endif

// ==== hw/csr_pkg.sv ====
`include "csr_cfg.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0] xlen_t;

    // bit 2 marks the immediate forms
    typedef enum logic [2:0] {
        csr_none = 3'd0,
        csr_rw   = 3'd1,
        csr_rs   = 3'd2,
        csr_rc   = 3'd3,
        csr_rwi  = 3'd5,
        csr_rsi  = 3'd6,
        csr_rci  = 3'd7
    } csr_op_e;

    typedef enum logic [11:0] {
        csr_mstatus       = 12'h300,
        csr_mie           = 12'h304,
        csr_mtvec         = 12'h305,
        csr_mcountinhibit = 12'h320,
        csr_mscratch      = 12'h340,
        csr_mepc          = 12'h341,
        csr_mcause        = 12'h342,
        csr_mtval         = 12'h343,
        csr_mip           = 12'h344,
        csr_mcycle        = 12'hb00,
        csr_minstret      = 12'hb02
    } csr_addr_e;

    typedef enum logic [1:0] {
        priv_u = 2'd0,
        priv_m = 2'd3
    } priv_mode_e;

    typedef enum logic [4:0] {
        exc_illegal_instr = 5'd2,
        exc_breakpoint    = 5'd3,
        exc_ecall         = 5'd8,
        exc_env_call      = 5'd24,
        exc_mret          = 5'd25
    } exc_code_e;

    // interrupt codes overlap exception codes, so they sit outside the enum list
    localparam exc_code_e exc_irq_msi = exc_code_e'(5'd3);
    localparam exc_code_e exc_irq_mti = exc_code_e'(5'd7);
    localparam exc_code_e exc_irq_mei = exc_code_e'(5'd11);

endpackage

// ==== hw/csr_access.sv ====
`timescale 1ns/1ps

module csr_access (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 csr_valid_i,
    input  csr_pkg::csr_op_e     csr_op_i,
    input  logic [11:0]          csr_addr_i,
    input  csr_pkg::xlen_t       csr_src_i,
    input  logic [4:0]           csr_imm_i,
    input  logic                 flush_i,
    input  csr_pkg::priv_mode_e  priv_i,
    input  csr_pkg::xlen_t       mstatus_i,
    input  csr_pkg::xlen_t       mtvec_i,
    input  csr_pkg::xlen_t       mepc_i,
    input  csr_pkg::xlen_t       mcause_i,
    input  csr_pkg::xlen_t       mtval_i,
    input  csr_pkg::xlen_t       mie_i,
    input  csr_pkg::xlen_t       mip_i,
    input  csr_pkg::xlen_t       mcountinhibit_i,
    input  csr_pkg::xlen_t       mcycle_i,
    input  csr_pkg::xlen_t       minstret_i,
    output csr_pkg::xlen_t       csr_rdata_o,
    output logic                 csr_illegal_o,
    output logic                 wr_en_o,
    output csr_pkg::csr_addr_e   wr_addr_o,
    output csr_pkg::xlen_t       wr_data_o
);
    import csr_pkg::*;

    logic      known;
    logic      is_write;
    logic      we;
    xlen_t     rdata;
    xlen_t     operand;
    xlen_t     wdata;
    xlen_t     mscratch;
    logic      s1_valid;
    logic      s2_valid;
    csr_addr_e s1_addr;
    csr_addr_e s2_addr;
    xlen_t     s1_data;
    xlen_t     s2_data;

    always_comb begin
        known = 1'b1;
        rdata = '0;
        case (csr_addr_i)
            csr_mstatus:       rdata = mstatus_i;
            csr_mie:           rdata = mie_i;
            csr_mtvec:         rdata = mtvec_i;
            csr_mcountinhibit: rdata = mcountinhibit_i;
            csr_mscratch:      rdata = mscratch;
            csr_mepc:          rdata = mepc_i;
            csr_mcause:        rdata = mcause_i;
            csr_mtval:         rdata = mtval_i;
            csr_mip:           rdata = mip_i;
            csr_mcycle:        rdata = mcycle_i;
            csr_minstret:      rdata = minstret_i;
            default:           known = 1'b0;
        endcase
    end

    assign operand = csr_op_i[2] ? xlen_t'(csr_imm_i) : csr_src_i;

    // set and clear with a zero operand only read
    always_comb begin
        case (csr_op_i)
            csr_rw, csr_rwi: begin
                wdata    = operand;
                is_write = 1'b1;
            end
            csr_rs, csr_rsi: begin
                wdata    = rdata | operand;
                is_write = |operand;
            end
            csr_rc, csr_rci: begin
                wdata    = rdata & ~operand;
                is_write = |operand;
            end
            default: begin
                wdata    = rdata;
                is_write = 1'b0;
            end
        endcase
    end

    // bits 9:8 give the lowest privilege allowed
    assign csr_illegal_o = csr_valid_i && (csr_op_i != csr_none) &&
                           (!known || (csr_addr_i[9:8] > priv_i));
    assign csr_rdata_o   = rdata;

    assign we = csr_valid_i && is_write && !csr_illegal_o && !flush_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= we;
            s2_valid <= s1_valid && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= csr_addr_e'(csr_addr_i);
        s1_data <= wdata;
        s2_addr <= s1_addr;
        s2_data <= s1_data;
    end

    assign wr_en_o   = s2_valid && !flush_i;
    assign wr_addr_o = s2_addr;
    assign wr_data_o = s2_data;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mscratch <= '0;
        end else if (wr_en_o && (wr_addr_o == csr_mscratch)) begin
            mscratch <= wr_data_o;
        end
    end

    // a flush kills both stages, nothing commits next cycle
    assert property (@(posedge clk) disable iff (!rst) flush_i |=> !wr_en_o);

endmodule

// ==== hw/csr_trap.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_trap (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 trap_i,
    input  csr_pkg::exc_code_e   trap_cause_i,
    input  logic                 trap_irq_i,
    input  csr_pkg::xlen_t       trap_pc_i,
    input  csr_pkg::xlen_t       trap_tval_i,
    input  logic                 mret_i,
    input  logic                 wr_en_i,
    input  csr_pkg::csr_addr_e   wr_addr_i,
    input  csr_pkg::xlen_t       wr_data_i,
    output csr_pkg::priv_mode_e  priv_o,
    output csr_pkg::xlen_t       mstatus_o,
    output csr_pkg::xlen_t       mtvec_o,
    output csr_pkg::xlen_t       mepc_o,
    output csr_pkg::xlen_t       mcause_o,
    output csr_pkg::xlen_t       mtval_o,
    output csr_pkg::xlen_t       target_pc_o
);
    import csr_pkg::*;

    priv_mode_e mode;
    priv_mode_e status_mpp;
    logic       status_mie;
    logic       status_mpie;
    xlen_t      mtvec;
    xlen_t      mepc;
    xlen_t      mcause;
    xlen_t      mtval;
    logic       ret_ok;
    logic       ret_bad;
    logic       take_trap;
    logic       cause_irq;
    exc_code_e  trap_code;
    xlen_t      vec_base;

    assign ret_ok    = mret_i && (mode == priv_m);
    assign ret_bad   = mret_i && (mode != priv_m);
    assign take_trap = trap_i || ret_bad;
    assign cause_irq = trap_irq_i && !ret_bad;

    always_comb begin
        if (ret_bad) begin
            trap_code = exc_illegal_instr;
        end else if (trap_cause_i == exc_env_call) begin
            // ecall from u gives 8, from m gives 11
            trap_code = exc_code_e'(5'd8 + {3'b000, mode});
        end else begin
            trap_code = trap_cause_i;
        end
    end

    assign vec_base = {mtvec[`CSR_XLEN-1:2], 2'b00};

    always_comb begin
        if (ret_ok) begin
            target_pc_o = mepc;
        end else if (cause_irq && (mtvec[1:0] == 2'b01)) begin
            target_pc_o = vec_base + xlen_t'({trap_code, 2'b00});
        end else begin
            target_pc_o = vec_base;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode        <= priv_m;
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            status_mpp  <= priv_u;
            mtvec       <= `CSR_MTVEC_RESET;
            mepc        <= '0;
            mcause      <= '0;
            mtval       <= '0;
        end else begin
            if (wr_en_i) begin
                case (wr_addr_i)
                    csr_mstatus: begin
                        status_mie  <= wr_data_i[`CSR_MSTATUS_MIE];
                        status_mpie <= wr_data_i[`CSR_MSTATUS_MPIE];
                        // only m and u exist, anything else reads back as u
                        status_mpp  <= (wr_data_i[`CSR_MSTATUS_MPP_LO +: 2] == 2'b11) ?
                                       priv_m : priv_u;
                    end
                    csr_mtvec:  mtvec  <= {wr_data_i[`CSR_XLEN-1:2], 1'b0, wr_data_i[0]};
                    csr_mepc:   mepc   <= wr_data_i;
                    csr_mcause: mcause <= wr_data_i;
                    csr_mtval:  mtval  <= wr_data_i;
                    default: ;
                endcase
            end
            // trap events win over a csr write in the same cycle
            if (take_trap) begin
                status_mpie <= status_mie;
                status_mie  <= 1'b0;
                status_mpp  <= mode;
                mode        <= priv_m;
                mepc        <= trap_pc_i;
                mcause      <= {cause_irq, {(`CSR_XLEN-6){1'b0}}, trap_code};
                mtval       <= cause_irq ? '0 : trap_tval_i;
            end else if (ret_ok) begin
                status_mie  <= status_mpie;
                status_mpie <= 1'b1;
                mode        <= status_mpp;
                status_mpp  <= priv_u;
            end
        end
    end

    always_comb begin
        mstatus_o = '0;
        mstatus_o[`CSR_MSTATUS_MIE] = status_mie;
        mstatus_o[`CSR_MSTATUS_MPIE] = status_mpie;
        mstatus_o[`CSR_MSTATUS_MPP_LO +: 2] = status_mpp;
    end

    assign priv_o  = mode;
    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;
    assign mcause_o = mcause;
    assign mtval_o = mtval;

    // the pipeline retires one event per cycle
    assert property (@(posedge clk) disable iff (!rst) !(trap_i && mret_i));

endmodule

// ==== hw/csr_irq.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_irq (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 soft_irq_i,
    input  logic                 timer_irq_i,
    input  logic                 ext_irq_i,
    input  csr_pkg::priv_mode_e  priv_i,
    input  logic                 mstatus_mie_i,
    input  logic                 wr_en_i,
    input  csr_pkg::csr_addr_e   wr_addr_i,
    input  csr_pkg::xlen_t       wr_data_i,
    output csr_pkg::xlen_t       mie_o,
    output csr_pkg::xlen_t       mip_o,
    output logic                 irq_o,
    output csr_pkg::exc_code_e   irq_cause_o
);
    import csr_pkg::*;

    localparam xlen_t irq_mask = (xlen_t'(1) << `CSR_IRQ_MSI) |
                                 (xlen_t'(1) << `CSR_IRQ_MTI) |
                                 (xlen_t'(1) << `CSR_IRQ_MEI);

    // line order is ext, timer, soft
    logic [2:0] sync_q;
    logic [2:0] pend_q;
    xlen_t      mie;
    xlen_t      pending;
    logic       enabled;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sync_q <= '0;
            pend_q <= '0;
            mie    <= '0;
        end else begin
            sync_q <= {ext_irq_i, timer_irq_i, soft_irq_i};
            pend_q <= sync_q;
            if (wr_en_i && (wr_addr_i == csr_mie)) begin
                mie <= wr_data_i & irq_mask;
            end
        end
    end

    always_comb begin
        mip_o = '0;
        mip_o[`CSR_IRQ_MEI] = pend_q[2];
        mip_o[`CSR_IRQ_MTI] = pend_q[1];
        mip_o[`CSR_IRQ_MSI] = pend_q[0];
    end

    // user mode is always interruptible by machine interrupts
    assign enabled = (priv_i == priv_u) || mstatus_mie_i;
    assign pending = mip_o & mie;
    assign irq_o   = enabled && (|pending);

    always_comb begin
        if (pending[`CSR_IRQ_MEI]) begin
            irq_cause_o = exc_irq_mei;
        end else if (pending[`CSR_IRQ_MSI]) begin
            irq_cause_o = exc_irq_msi;
        end else begin
            irq_cause_o = exc_irq_mti;
        end
    end

    assign mie_o = mie;

    // an interrupt only follows a line seen two edges earlier
    assert property (@(posedge clk) disable iff (!rst)
        irq_o |-> ($past(ext_irq_i, 2) || $past(timer_irq_i, 2) || $past(soft_irq_i, 2)));

endmodule

// ==== hw/csr_counters.sv ====
`timescale 1ns/1ps

module csr_counters (
    input  logic                clk,
    input  logic                rst,
    input  logic [1:0]          retire_num_i,
    input  logic                wr_en_i,
    input  csr_pkg::csr_addr_e  wr_addr_i,
    input  csr_pkg::xlen_t      wr_data_i,
    output csr_pkg::xlen_t      mcycle_o,
    output csr_pkg::xlen_t      minstret_o,
    output csr_pkg::xlen_t      mcountinhibit_o
);
    import csr_pkg::*;

    logic  inhibit_cy;
    logic  inhibit_ir;
    xlen_t mcycle;
    xlen_t minstret;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            inhibit_cy <= 1'b0;
            inhibit_ir <= 1'b0;
            mcycle     <= '0;
            minstret   <= '0;
        end else begin
            if (wr_en_i && (wr_addr_i == csr_mcountinhibit)) begin
                inhibit_cy <= wr_data_i[0];
                inhibit_ir <= wr_data_i[2];
            end
            if (!inhibit_cy) begin
                mcycle <= mcycle + 1'b1;
            end
            // up to three retirements per cycle
            if (!inhibit_ir) begin
                minstret <= minstret + xlen_t'(retire_num_i);
            end
        end
    end

    assign mcycle_o        = mcycle;
    assign minstret_o      = minstret;
    assign mcountinhibit_o = xlen_t'({inhibit_ir, 1'b0, inhibit_cy});

endmodule

// ==== hw/csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module csr_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 csr_valid_i,
    input  csr_pkg::csr_op_e     csr_op_i,
    input  logic [11:0]          csr_addr_i,
    input  csr_pkg::xlen_t       csr_src_i,
    input  logic [4:0]           csr_imm_i,
    input  logic                 flush_i,
    output csr_pkg::xlen_t       csr_rdata_o,
    output logic                 csr_illegal_o,
    input  logic                 trap_i,
    input  csr_pkg::exc_code_e   trap_cause_i,
    input  logic                 trap_irq_i,
    input  csr_pkg::xlen_t       trap_pc_i,
    input  csr_pkg::xlen_t       trap_tval_i,
    input  logic                 mret_i,
    output csr_pkg::xlen_t       target_pc_o,
    input  logic                 soft_irq_i,
    input  logic                 timer_irq_i,
    input  logic                 ext_irq_i,
    output logic                 irq_o,
    output csr_pkg::exc_code_e   irq_cause_o,
    input  logic [1:0]           retire_num_i,
    output csr_pkg::priv_mode_e  priv_o
);

    logic               wr_en;
    csr_pkg::csr_addr_e wr_addr;
    csr_pkg::xlen_t     wr_data;
    csr_pkg::xlen_t     mstatus;
    csr_pkg::xlen_t     mtvec;
    csr_pkg::xlen_t     mepc;
    csr_pkg::xlen_t     mcause;
    csr_pkg::xlen_t     mtval;
    csr_pkg::xlen_t     mie;
    csr_pkg::xlen_t     mip;
    csr_pkg::xlen_t     mcountinhibit;
    csr_pkg::xlen_t     mcycle;
    csr_pkg::xlen_t     minstret;

    csr_access u_access (
        .clk(clk), .rst(rst),
        .csr_valid_i(csr_valid_i), .csr_op_i(csr_op_i), .csr_addr_i(csr_addr_i),
        .csr_src_i(csr_src_i), .csr_imm_i(csr_imm_i), .flush_i(flush_i), .priv_i(priv_o),
        .mstatus_i(mstatus), .mtvec_i(mtvec), .mepc_i(mepc), .mcause_i(mcause),
        .mtval_i(mtval), .mie_i(mie), .mip_i(mip), .mcountinhibit_i(mcountinhibit),
        .mcycle_i(mcycle), .minstret_i(minstret),
        .csr_rdata_o(csr_rdata_o), .csr_illegal_o(csr_illegal_o),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data)
    );

    csr_trap u_trap (
        .clk(clk), .rst(rst),
        .trap_i(trap_i), .trap_cause_i(trap_cause_i), .trap_irq_i(trap_irq_i),
        .trap_pc_i(trap_pc_i), .trap_tval_i(trap_tval_i), .mret_i(mret_i),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .priv_o(priv_o), .mstatus_o(mstatus), .mtvec_o(mtvec), .mepc_o(mepc),
        .mcause_o(mcause), .mtval_o(mtval), .target_pc_o(target_pc_o)
    );

    csr_irq u_irq (
        .clk(clk), .rst(rst),
        .soft_irq_i(soft_irq_i), .timer_irq_i(timer_irq_i), .ext_irq_i(ext_irq_i),
        .priv_i(priv_o), .mstatus_mie_i(mstatus[`CSR_MSTATUS_MIE]),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .mie_o(mie), .mip_o(mip), .irq_o(irq_o), .irq_cause_o(irq_cause_o)
    );

    csr_counters u_counters (
        .clk(clk), .rst(rst), .retire_num_i(retire_num_i),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .mcycle_o(mcycle), .minstret_o(minstret), .mcountinhibit_o(mcountinhibit)
    );

endmodule

// ==== sim/tb_csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_cfg.svh"

module tb_csr_unit;
    import csr_pkg::*;

    // rough test lengths in cycles, the watchdog allows twice their sum
    localparam int len_reset   = 4;
    localparam int len_rmw     = 40;
    localparam int len_flush   = 20;
    localparam int len_illegal = 30;
    localparam int len_trap    = 30;
    localparam int len_irq     = 30;
    localparam int len_count   = 90;
    localparam int run_cycles  = 2 * (len_reset + len_rmw + len_flush + len_illegal +
                                      len_trap + len_irq + len_count);

    logic       clk = 1'b0;
    logic       rst;
    logic       csr_valid_i;
    csr_op_e    csr_op_i;
    logic [11:0] csr_addr_i;
    xlen_t      csr_src_i;
    logic [4:0] csr_imm_i;
    logic       flush_i;
    xlen_t      csr_rdata_o;
    logic       csr_illegal_o;
    logic       trap_i;
    exc_code_e  trap_cause_i;
    logic       trap_irq_i;
    xlen_t      trap_pc_i;
    xlen_t      trap_tval_i;
    logic       mret_i;
    xlen_t      target_pc_o;
    logic       soft_irq_i;
    logic       timer_irq_i;
    logic       ext_irq_i;
    logic       irq_o;
    exc_code_e  irq_cause_o;
    logic [1:0] retire_num_i;
    priv_mode_e priv_o;
    int         error_count = 0;

    csr_unit uut (
        .clk(clk), .rst(rst),
        .csr_valid_i(csr_valid_i), .csr_op_i(csr_op_i), .csr_addr_i(csr_addr_i),
        .csr_src_i(csr_src_i), .csr_imm_i(csr_imm_i), .flush_i(flush_i),
        .csr_rdata_o(csr_rdata_o), .csr_illegal_o(csr_illegal_o),
        .trap_i(trap_i), .trap_cause_i(trap_cause_i), .trap_irq_i(trap_irq_i),
        .trap_pc_i(trap_pc_i), .trap_tval_i(trap_tval_i), .mret_i(mret_i),
        .target_pc_o(target_pc_o),
        .soft_irq_i(soft_irq_i), .timer_irq_i(timer_irq_i), .ext_irq_i(ext_irq_i),
        .irq_o(irq_o), .irq_cause_o(irq_cause_o),
        .retire_num_i(retire_num_i), .priv_o(priv_o)
    );

    always #5 clk = ~clk;

    task automatic check_eq(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // replace, set or clear applied to the old value
    function automatic xlen_t next_value(input csr_op_e op, input xlen_t old,
                                         input xlen_t src, input logic [4:0] imm);
        xlen_t operand;
        operand = (op == csr_rwi || op == csr_rsi || op == csr_rci) ? xlen_t'(imm) : src;
        case (op)
            csr_rw, csr_rwi: return operand;
            csr_rs, csr_rsi: return old | operand;
            csr_rc, csr_rci: return old & ~operand;
            default:         return old;
        endcase
    endfunction

    // one-cycle request, called on a falling edge and returns on the next one
    task automatic issue_csr(input csr_op_e op, input logic [11:0] addr, input xlen_t src,
                             input logic [4:0] imm, output xlen_t rdata, output logic illegal);
        csr_valid_i = 1'b1;
        csr_op_i    = op;
        csr_addr_i  = addr;
        csr_src_i   = src;
        csr_imm_i   = imm;
        #1;
        rdata   = csr_rdata_o;
        illegal = csr_illegal_o;
        @(negedge clk);
        csr_valid_i = 1'b0;
        csr_op_i    = csr_none;
    endtask

    task automatic read_csr(input logic [11:0] addr, output xlen_t data);
        logic ill;
        issue_csr(csr_rs, addr, '0, 5'd0, data, ill);
        check_eq("csr_illegal_o", xlen_t'(ill), 0);
    endtask

    task automatic expect_csr(input string name, input logic [11:0] addr, input xlen_t exp);
        xlen_t data;
        read_csr(addr, data);
        check_eq(name, data, exp);
    endtask

    // returns once the write has committed
    task automatic write_csr(input logic [11:0] addr, input xlen_t data);
        xlen_t rdata;
        logic  ill;
        issue_csr(csr_rw, addr, data, 5'd0, rdata, ill);
        check_eq("csr_illegal_o", xlen_t'(ill), 0);
        wait_cycles(2);
    endtask

    task automatic do_trap(input exc_code_e cause, input logic irq, input xlen_t pc,
                           input xlen_t tval, output xlen_t target);
        trap_i       = 1'b1;
        trap_cause_i = cause;
        trap_irq_i   = irq;
        trap_pc_i    = pc;
        trap_tval_i  = tval;
        #1;
        target = target_pc_o;
        @(negedge clk);
        trap_i     = 1'b0;
        trap_irq_i = 1'b0;
    endtask

    task automatic do_mret(output xlen_t target);
        mret_i = 1'b1;
        #1;
        target = target_pc_o;
        @(negedge clk);
        mret_i = 1'b0;
    endtask

    task automatic test_reset_rmw();
        csr_op_e     ops [7];
        xlen_t       model;
        xlen_t       src;
        xlen_t       rdata;
        logic [31:0] rnd;
        logic [4:0]  imm;
        logic        ill;
        ops = '{csr_rw, csr_rs, csr_rc, csr_rwi, csr_rsi, csr_rci, csr_rs};
        expect_csr("mtvec", csr_mtvec, `CSR_MTVEC_RESET);
        expect_csr("mscratch", csr_mscratch, '0);
        model = '0;
        foreach (ops[i]) begin
            rnd = $urandom;
            imm = rnd[4:0];
            // last pass is rs with a zero source
            src = (i == 6) ? '0 : xlen_t'($urandom);
            issue_csr(ops[i], csr_mscratch, src, imm, rdata, ill);
            check_eq("csr_rdata_o", rdata, model);
            check_eq("csr_illegal_o", xlen_t'(ill), 0);
            model = next_value(ops[i], model, src, imm);
            wait_cycles(2);
            expect_csr("mscratch", csr_mscratch, model);
        end
    endtask

    task automatic test_flush();
        xlen_t old_val;
        xlen_t new_val;
        xlen_t rdata;
        logic  ill;
        old_val = $urandom;
        new_val = ~old_val;
        write_csr(csr_mscratch, old_val);
        issue_csr(csr_rw, csr_mscratch, new_val, 5'd0, rdata, ill);
        // write sits in stage 1 now
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        wait_cycles(1);
        expect_csr("mscratch", csr_mscratch, old_val);
        // flush in the request cycle keeps it out of the pipeline
        flush_i = 1'b1;
        issue_csr(csr_rw, csr_mscratch, new_val, 5'd0, rdata, ill);
        flush_i = 1'b0;
        wait_cycles(2);
        expect_csr("mscratch", csr_mscratch, old_val);
        issue_csr(csr_rw, csr_mscratch, new_val, 5'd0, rdata, ill);
        wait_cycles(2);
        // stage 2 edge already passed
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
        expect_csr("mscratch", csr_mscratch, new_val);
    endtask

    task automatic test_illegal();
        xlen_t keep;
        xlen_t rdata;
        xlen_t target;
        logic  ill;
        keep = $urandom;
        write_csr(csr_mscratch, keep);
        issue_csr(csr_rw, 12'h7c0, ~keep, 5'd0, rdata, ill);
        check_eq("csr_illegal_o", xlen_t'(ill), 1);
        wait_cycles(2);
        expect_csr("mscratch", csr_mscratch, keep);
        // trap, clear mpp, then mret lands in u
        do_trap(exc_breakpoint, 1'b0, 32'h0000_1000, '0, target);
        write_csr(csr_mstatus, '0);
        do_mret(target);
        check_eq("priv_o", xlen_t'(priv_o), xlen_t'(priv_u));
        issue_csr(csr_rs, csr_mstatus, '0, 5'd0, rdata, ill);
        check_eq("csr_illegal_o", xlen_t'(ill), 1);
        issue_csr(csr_rw, csr_mscratch, ~keep, 5'd0, rdata, ill);
        check_eq("csr_illegal_o", xlen_t'(ill), 1);
        wait_cycles(2);
        // ecall from u goes back to m with cause 8
        do_trap(exc_env_call, 1'b0, 32'h0000_2000, '0, target);
        check_eq("priv_o", xlen_t'(priv_o), xlen_t'(priv_m));
        expect_csr("mcause", csr_mcause, 32'd8);
        expect_csr("mscratch", csr_mscratch, keep);
    endtask

    task automatic test_trap_mret();
        xlen_t base;
        xlen_t pc;
        xlen_t tval;
        xlen_t target;
        base = $urandom;
        base[1:0] = 2'b00;
        pc = $urandom;
        tval = $urandom;
        write_csr(csr_mtvec, base);
        write_csr(csr_mstatus, xlen_t'(1) << `CSR_MSTATUS_MIE);
        do_trap(exc_breakpoint, 1'b0, pc, tval, target);
        check_eq("target_pc_o", target, base);
        check_eq("priv_o", xlen_t'(priv_o), xlen_t'(priv_m));
        expect_csr("mepc", csr_mepc, pc);
        expect_csr("mcause", csr_mcause, 32'd3);
        expect_csr("mtval", csr_mtval, tval);
        expect_csr("mstatus", csr_mstatus,
                   (xlen_t'(1) << `CSR_MSTATUS_MPIE) | (xlen_t'(3) << `CSR_MSTATUS_MPP_LO));
        do_mret(target);
        check_eq("target_pc_o", target, pc);
        check_eq("priv_o", xlen_t'(priv_o), xlen_t'(priv_m));
        expect_csr("mstatus", csr_mstatus,
                   (xlen_t'(1) << `CSR_MSTATUS_MIE) | (xlen_t'(1) << `CSR_MSTATUS_MPIE));
        // mpp is u now
        do_mret(target);
        check_eq("target_pc_o", target, pc);
        check_eq("priv_o", xlen_t'(priv_o), xlen_t'(priv_u));
        do_mret(target);
        check_eq("target_pc_o", target, base);
        check_eq("priv_o", xlen_t'(priv_o), xlen_t'(priv_m));
        expect_csr("mcause", csr_mcause, 32'd2);
    endtask

    task automatic test_irq();
        xlen_t rdata;
        logic  ill;
        write_csr(csr_mie, (xlen_t'(1) << `CSR_IRQ_MTI) | (xlen_t'(1) << `CSR_IRQ_MEI));
        write_csr(csr_mstatus, xlen_t'(1) << `CSR_MSTATUS_MIE);
        timer_irq_i = 1'b1;
        #1;
        check_eq("irq_o", xlen_t'(irq_o), 0);
        @(negedge clk);
        check_eq("irq_o", xlen_t'(irq_o), 0);
        @(negedge clk);
        check_eq("irq_o", xlen_t'(irq_o), 1);
        check_eq("irq_cause_o", xlen_t'(irq_cause_o), 32'd7);
        ext_irq_i = 1'b1;
        wait_cycles(2);
        check_eq("irq_o", xlen_t'(irq_o), 1);
        check_eq("irq_cause_o", xlen_t'(irq_cause_o), 32'd11);
        expect_csr("mip", csr_mip, (xlen_t'(1) << `CSR_IRQ_MTI) | (xlen_t'(1) << `CSR_IRQ_MEI));
        issue_csr(csr_rc, csr_mstatus, xlen_t'(1) << `CSR_MSTATUS_MIE, 5'd0, rdata, ill);
        wait_cycles(2);
        check_eq("priv_o", xlen_t'(priv_o), xlen_t'(priv_m));
        check_eq("irq_o", xlen_t'(irq_o), 0);
        timer_irq_i = 1'b0;
        ext_irq_i   = 1'b0;
        wait_cycles(2);
    endtask

    task automatic test_counters();
        xlen_t       first;
        xlen_t       second;
        xlen_t       first_ir;
        xlen_t       second_ir;
        logic [31:0] rnd;
        int unsigned gap;
        int unsigned step;
        rnd  = $urandom;
        gap  = 4 + rnd % 16;
        step = 1 + (rnd >> 8) % 3;
        read_csr(csr_mcycle, first);
        wait_cycles(gap - 1);
        read_csr(csr_mcycle, second);
        check_eq("mcycle delta", second - first, gap);
        retire_num_i = 2'(step);
        read_csr(csr_minstret, first);
        wait_cycles(gap - 1);
        read_csr(csr_minstret, second);
        check_eq("minstret delta", second - first, gap * step);
        write_csr(csr_mcountinhibit, 32'h5);
        expect_csr("mcountinhibit", csr_mcountinhibit, 32'h5);
        read_csr(csr_mcycle, first);
        read_csr(csr_minstret, first_ir);
        wait_cycles(gap);
        read_csr(csr_mcycle, second);
        read_csr(csr_minstret, second_ir);
        check_eq("mcycle", second, first);
        check_eq("minstret", second_ir, first_ir);
        retire_num_i = 2'd0;
        write_csr(csr_mcountinhibit, '0);
    endtask

    initial begin
        void'($urandom(1266));
        rst          = 1'b0;
        csr_valid_i  = 1'b0;
        csr_op_i     = csr_none;
        csr_addr_i   = '0;
        csr_src_i    = '0;
        csr_imm_i    = '0;
        flush_i      = 1'b0;
        trap_i       = 1'b0;
        trap_cause_i = exc_breakpoint;
        trap_irq_i   = 1'b0;
        trap_pc_i    = '0;
        trap_tval_i  = '0;
        mret_i       = 1'b0;
        soft_irq_i   = 1'b0;
        timer_irq_i  = 1'b0;
        ext_irq_i    = 1'b0;
        retire_num_i = 2'd0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        test_reset_rmw();
        test_flush();
        test_illegal();
        test_trap_mret();
        test_irq();
        test_counters();
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "checks failed");
        end
    end

    initial begin
        #(run_cycles * 10);
        $display("timeout: the tests did not finish within %0d cycles", run_cycles);
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== build.f ====
+incdir+hw
hw/csr_pkg.sv
hw/csr_access.sv
hw/csr_trap.sv
hw/csr_irq.sv
hw/csr_counters.sv
hw/csr_unit.sv
sim/tb_csr_unit.sv

// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - hw

sources:
  - hw/csr_pkg.sv
  - hw/csr_access.sv
  - hw/csr_trap.sv
  - hw/csr_irq.sv
  - hw/csr_counters.sv
  - hw/csr_unit.sv
  - target: simulation
    files:
      - sim/tb_csr_unit.sv
